// File: sim.f
source/CorePkg.sv
source/InstructionDecoder.sv
source/WatchdogTimer.sv
source/RegisterFile.sv
source/DecodeStage.sv
source/DecodeFrontEnd.sv
testbench/DecodeFrontEndTb.sv

// File: Bender.yml
package:
  name: decode_front_end

sources:
  - source/CorePkg.sv
  - source/InstructionDecoder.sv
  - source/WatchdogTimer.sv
  - source/RegisterFile.sv
  - source/DecodeStage.sv
  - source/DecodeFrontEnd.sv
  - target: test
    files:
      - testbench/DecodeFrontEndTb.sv

// File: testbench/DecodeFrontEndTb.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeFrontEndTb;

    localparam int WdLimit = 20;

    logic clock;
    logic reset;
    CorePkg::InstructionWord instruction;
    logic instrValid;
    logic isUserRequest;
    logic watchdogKick;
    logic [15:0] pc;
    logic wrEnable;
    logic [3:0] wrAddr;
    logic [15:0] wrData;
    logic decValid;
    logic [6:0] decId;
    logic [3:0] decRegD;
    logic [3:0] decRegA;
    logic [3:0] decRegB;
    logic [11:0] decOffset;
    logic [3:0] decCondition;
    logic [15:0] decOperandA;
    logic [15:0] decOperandB;
    logic wdInterrupt;

    // Expected fields set with each word and delayed one edge for the checks
    logic [6:0] expId, expIdQ;
    logic [3:0] expRegD, expRegDQ, expRegA, expRegAQ, expCond, expCondQ;
    logic [3:0] expRegB, expRegBQ;
    logic [11:0] expOffset, expOffsetQ;
    logic [15:0] expOpA, expOpAQ, expOpB, expOpBQ;
    logic chkId, chkRegD, chkRegA, chkRegB, chkOffset, chkCond, chkOpA, chkOpB;

    string testName;
    int valueErrors;
    int otherErrors;
    logic [31:0] rngState;
    logic [15:0] written [8];
    logic kickEnable;
    int kickTimer;

    DecodeFrontEnd #(.LinkRegister(12), .WatchdogLimit(WdLimit)) dut0 (
        .clock, .reset, .instruction, .instrValid, .isUserRequest, .watchdogKick,
        .pc, .wrEnable, .wrAddr, .wrData, .decValid, .decId, .decRegD, .decRegA,
        .decRegB, .decOffset, .decCondition, .decOperandA, .decOperandB, .wdInterrupt
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        expIdQ     <= expId;
        expRegDQ   <= expRegD;
        expRegAQ   <= expRegA;
        expRegBQ   <= expRegB;
        expOffsetQ <= expOffset;
        expCondQ   <= expCond;
        expOpAQ    <= expOpA;
        expOpBQ    <= expOpB;
    end

    // Watchdog kick every 10 cycles while enabled
    always begin
        @(posedge clock);
        #1;
        kickTimer = (kickTimer == 9) ? 0 : kickTimer + 1;
        watchdogKick = kickEnable && (kickTimer == 0);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output logic [15:0] v);
        rngState = xorshift32(rngState);
        v = rngState[15:0];
    endtask

    task automatic clearChecks();
        chkId = 1'b0;
        chkRegD = 1'b0;
        chkRegA = 1'b0;
        chkRegB = 1'b0;
        chkOffset = 1'b0;
        chkCond = 1'b0;
        chkOpA = 1'b0;
        chkOpB = 1'b0;
    endtask

    task automatic sendWord(input logic [15:0] w);
        instruction = w;
        instrValid = 1'b1;   // One cycle strobe
        @(posedge clock);
        #1;
        instrValid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    assert property (@(posedge clock) $fell(reset) |-> !decValid && !wdInterrupt)
        else begin
            otherErrors++;
            $display("decValid or wdInterrupt was high right after reset");
        end
    assert property (@(posedge clock) disable iff (reset) instrValid |=> decValid)
        else begin
            otherErrors++;
            $display("%s: decValid missing one cycle after instrValid", testName);
        end
    assert property (@(posedge clock) disable iff (reset) !instrValid |=> !decValid)
        else begin
            otherErrors++;
            $display("%s: decValid high without a word", testName);
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && wdInterrupt |=> !wdInterrupt)
        else begin
            otherErrors++;
            $display("%s: wdInterrupt stayed high after the system call", testName);
        end

    assert property (@(posedge clock) disable iff (reset) instrValid && chkId |=> decId == expIdQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s id: expected %h actual %h", testName, $sampled(expIdQ),
                $sampled(decId));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkRegD |=> decRegD == expRegDQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s regD: expected %h actual %h", testName, $sampled(expRegDQ),
                $sampled(decRegD));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkRegA |=> decRegA == expRegAQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s regA: expected %h actual %h", testName, $sampled(expRegAQ),
                $sampled(decRegA));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkRegB |=> decRegB == expRegBQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s regB: expected %h actual %h", testName, $sampled(expRegBQ),
                $sampled(decRegB));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkOffset |=> decOffset == expOffsetQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s offset: expected %h actual %h", testName, $sampled(expOffsetQ),
                $sampled(decOffset));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkCond |=> decCondition == expCondQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s condition: expected %h actual %h", testName, $sampled(expCondQ),
                $sampled(decCondition));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkOpA |=> decOperandA == expOpAQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s operandA: expected %h actual %h", testName, $sampled(expOpAQ),
                $sampled(decOperandA));
        end
    assert property (@(posedge clock) disable iff (reset)
        instrValid && chkOpB |=> decOperandB == expOpBQ)
        else begin
            valueErrors++;
            $display("[ERROR] %s operandB: expected %h actual %h", testName, $sampled(expOpBQ),
                $sampled(decOperandB));
        end

    initial begin
        CorePkg::InstructionWord w;
        logic [15:0] r;
        logic [15:0] f;
        int cycles;
        reset = 1'b1;
        instruction = '0;
        instrValid = 1'b0;
        isUserRequest = 1'b0;
        watchdogKick = 1'b0;
        pc = '0;
        wrEnable = 1'b0;
        wrAddr = '0;
        wrData = '0;
        kickEnable = 1'b1;
        kickTimer = 0;
        valueErrors = 0;
        otherErrors = 0;
        rngState = 32'h42619191;
        testName = "reset";
        {expId, expRegD, expRegA, expRegB, expOffset, expCond, expOpA, expOpB} = '0;
        clearChecks();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        testName = "validTiming";   // Spaced words, then back to back
        for (int i = 0; i < 4; i++) begin
            nextRandom(r);
            sendWord(r);
            idleCycles(1);
        end
        for (int i = 0; i < 6; i++) begin
            nextRandom(r);
            sendWord(r);
        end
        idleCycles(2);

        testName = "regForm";
        chkId = 1'b1;
        chkRegD = 1'b1;
        chkRegA = 1'b1;
        chkRegB = 1'b1;
        chkOffset = 1'b1;
        chkCond = 1'b1;
        expRegB = '0;   // Unused in these forms
        for (int i = 0; i < 12; i++) begin
            nextRandom(r);
            w = r;
            w.regForm.opcode = 4'd6 + 4'(i % 3);
            f = w;
            expId = 7'h30 + 7'(2 * (i % 3)) + 7'(f[11]);
            expRegD = {1'b0, f[2:0]};
            expRegA = {1'b0, f[5:3]};
            expOffset = {7'b0, f[10:6]};
            expCond = CorePkg::CondNone;
            sendWord(f);
        end
        idleCycles(1);

        testName = "immForm";
        for (int i = 0; i < 12; i++) begin
            nextRandom(r);
            w = r;
            w.immForm.opcode = (i % 2 == 1) ? 4'd3 : 4'd2;
            f = w;
            expId = ((i % 2 == 1) ? 7'h0a : 7'h08) + 7'(f[11]);
            expRegD = {1'b0, f[10:8]};
            expRegA = {1'b0, f[10:8]};
            expOffset = {4'b0, f[7:0]};
            expCond = CorePkg::CondNone;
            sendWord(f);
        end
        chkRegD = 1'b0;
        chkOffset = 1'b0;
        for (int i = 0; i < 6; i++) begin   // Conditional branch
            nextRandom(r);
            w = r;
            w.immForm.opcode = 4'd13;
            f = w;
            expId = 7'h49;
            expRegA = CorePkg::RegProgramCounter;
            expCond = f[11:8];
            sendWord(f);
        end
        idleCycles(1);

        testName = "watchdog";
        clearChecks();
        kickEnable = 1'b0;
        idleCycles(1);   // Lets a kick already in flight land
        cycles = 0;
        while (!wdInterrupt && cycles < WdLimit + 2) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!wdInterrupt) begin
            otherErrors++;
            $display("wdInterrupt did not rise within %0d cycles", WdLimit + 2);
        end
        chkId = 1'b1;
        chkOffset = 1'b1;
        expId = CorePkg::IdSystemCall;
        expOffset = 12'd0;
        nextRandom(r);
        sendWord(r);
        kickEnable = 1'b1;
        idleCycles(2);

        testName = "userRequest";
        expOffset = 12'd3;
        isUserRequest = 1'b1;
        for (int i = 0; i < 8; i++) begin
            nextRandom(r);
            sendWord(r);
        end
        isUserRequest = 1'b0;
        idleCycles(1);

        testName = "operands";
        clearChecks();
        nextRandom(r);
        pc = r;
        for (int i = 0; i < 8; i++) begin
            nextRandom(r);
            written[i] = r;
            wrEnable = 1'b1;
            wrAddr = 4'(i);
            wrData = r;
            @(posedge clock);
            #1;
        end
        wrEnable = 1'b0;
        chkRegB = 1'b1;
        chkOpA = 1'b1;
        chkOpB = 1'b1;
        for (int i = 0; i < 10; i++) begin
            nextRandom(r);
            w = r;
            w.regForm.opcode = 4'd5;
            f = w;
            expRegB = {1'b0, f[8:6]};
            expOpA = written[f[5:3]];
            expOpB = written[f[8:6]];
            sendWord(f);
        end
        clearChecks();
        chkRegA = 1'b1;
        chkOpA = 1'b1;
        nextRandom(r);
        w = r;
        w.immForm.opcode = 4'd13;   // Reads register 15
        expRegA = CorePkg::RegProgramCounter;
        expOpA = pc;
        sendWord(w);
        idleCycles(1);

        testName = "resetWord";
        clearChecks();
        chkId = 1'b1;
        expId = CorePkg::IdReset;
        sendWord(16'hffff);
        idleCycles(2);

        $display("Closing counts: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Upper bound on the whole run
    initial begin
        for (int t = 0; t < 1000; t++) begin
            @(posedge clock);
        end
        $display("Simulation did not finish within 1000 cycles");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/DecodeFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeFrontEnd #(
    parameter int LinkRegister  = 12,
    parameter int WatchdogLimit = 64
) (
    input  logic                               clock,
    input  logic                               reset,
    input  CorePkg::InstructionWord            instruction,
    input  logic                               instrValid,
    input  logic                               isUserRequest,
    input  logic                               watchdogKick,
    input  logic [CorePkg::InstrWidth-1:0]     pc,
    input  logic                               wrEnable,
    input  logic [CorePkg::RegWidth-1:0]       wrAddr,
    input  logic [CorePkg::InstrWidth-1:0]     wrData,
    output logic                               decValid,
    output logic [CorePkg::IdWidth-1:0]        decId,
    output logic [CorePkg::RegWidth-1:0]       decRegD,
    output logic [CorePkg::RegWidth-1:0]       decRegA,
    output logic [CorePkg::RegWidth-1:0]       decRegB,
    output logic [CorePkg::OffsetWidth-1:0]    decOffset,
    output logic [CorePkg::CondWidth-1:0]      decCondition,
    output logic [CorePkg::InstrWidth-1:0]     decOperandA,
    output logic [CorePkg::InstrWidth-1:0]     decOperandB,
    output logic                               wdInterrupt
);

    logic                             wdInterruption;
    logic [CorePkg::IdWidth-1:0]      id;
    logic [CorePkg::RegWidth-1:0]     regD;
    logic [CorePkg::RegWidth-1:0]     regA;
    logic [CorePkg::RegWidth-1:0]     regB;
    logic [CorePkg::OffsetWidth-1:0]  offset;
    logic [CorePkg::CondWidth-1:0]    branchCondition;
    logic [CorePkg::InstrWidth-1:0]   operandA;
    logic [CorePkg::InstrWidth-1:0]   operandB;

    InstructionDecoder #(.LinkRegister(LinkRegister)) decoder0 (
        .instruction, .isUserRequest, .wdInterruption,
        .id, .regD, .regA, .regB, .offset, .branchCondition
    );

    WatchdogTimer #(.WatchdogLimit(WatchdogLimit)) watchdog0 (
        .clock, .reset, .watchdogKick, .instrValid, .wdInterruption
    );

    RegisterFile regFile0 (
        .clock, .reset, .wrEnable, .wrAddr, .wrData, .pc,
        .rdAddrA(regA), .rdAddrB(regB),   // Operands follow decoder fields
        .rdDataA(operandA), .rdDataB(operandB)
    );

    DecodeStage stage0 (
        .clock, .reset, .instrValid,
        .id, .regD, .regA, .regB, .offset, .branchCondition, .operandA, .operandB,
        .decValid, .decId, .decRegD, .decRegA, .decRegB, .decOffset, .decCondition,
        .decOperandA, .decOperandB
    );

    assign wdInterrupt = wdInterruption;

endmodule

`default_nettype wire

// File: source/DecodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeStage (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               instrValid,
    input  logic [CorePkg::IdWidth-1:0]        id,
    input  logic [CorePkg::RegWidth-1:0]       regD,
    input  logic [CorePkg::RegWidth-1:0]       regA,
    input  logic [CorePkg::RegWidth-1:0]       regB,
    input  logic [CorePkg::OffsetWidth-1:0]    offset,
    input  logic [CorePkg::CondWidth-1:0]      branchCondition,
    input  logic [CorePkg::InstrWidth-1:0]     operandA,
    input  logic [CorePkg::InstrWidth-1:0]     operandB,
    output logic                               decValid,
    output logic [CorePkg::IdWidth-1:0]        decId,
    output logic [CorePkg::RegWidth-1:0]       decRegD,
    output logic [CorePkg::RegWidth-1:0]       decRegA,
    output logic [CorePkg::RegWidth-1:0]       decRegB,
    output logic [CorePkg::OffsetWidth-1:0]    decOffset,
    output logic [CorePkg::CondWidth-1:0]      decCondition,
    output logic [CorePkg::InstrWidth-1:0]     decOperandA,
    output logic [CorePkg::InstrWidth-1:0]     decOperandB
);

    always_ff @(posedge clock) begin
        if (reset) decValid <= 1'b0;
        else decValid <= instrValid;   // One cycle pulse per word
    end

    // Payload only moves with a word
    always_ff @(posedge clock) begin
        if (instrValid) begin
            decId        <= id;
            decRegD      <= regD;
            decRegA      <= regA;
            decRegB      <= regB;
            decOffset    <= offset;
            decCondition <= branchCondition;
            decOperandA  <= operandA;
            decOperandB  <= operandB;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        decValid && !instrValid |=> !decValid);

endmodule

`default_nettype wire

// File: source/RegisterFile.sv
`timescale 1ns/100ps
`default_nettype none

module RegisterFile (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             wrEnable,
    input  logic [CorePkg::RegWidth-1:0]     wrAddr,
    input  logic [CorePkg::InstrWidth-1:0]   wrData,
    input  logic [CorePkg::InstrWidth-1:0]   pc,
    input  logic [CorePkg::RegWidth-1:0]     rdAddrA,
    input  logic [CorePkg::RegWidth-1:0]     rdAddrB,
    output logic [CorePkg::InstrWidth-1:0]   rdDataA,
    output logic [CorePkg::InstrWidth-1:0]   rdDataB
);

    logic [CorePkg::InstrWidth-1:0] regs [2**CorePkg::RegWidth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**CorePkg::RegWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable && wrAddr != CorePkg::RegProgramCounter) begin
            regs[wrAddr] <= wrData;   // Visible after the edge
        end
    end

    // PC is not stored here
    assign rdDataA = (rdAddrA == CorePkg::RegProgramCounter) ? pc : regs[rdAddrA];
    assign rdDataB = (rdAddrB == CorePkg::RegProgramCounter) ? pc : regs[rdAddrB];

    assert property (@(posedge clock) disable iff (reset)
        wrEnable |-> wrAddr != CorePkg::RegProgramCounter);

endmodule

`default_nettype wire

// File: source/WatchdogTimer.sv
`timescale 1ns/100ps
`default_nettype none

module WatchdogTimer #(
    parameter int WatchdogLimit = 64
) (
    input  logic clock,
    input  logic reset,
    input  logic watchdogKick,
    input  logic instrValid,
    output logic wdInterruption
);

    localparam int CountWidth = $clog2(WatchdogLimit + 1);
    localparam logic [CountWidth-1:0] CountMax = CountWidth'(WatchdogLimit);

    logic [CountWidth-1:0] count;
    logic pending;
    logic accepted;

    assign accepted = pending && instrValid;   // Word turned into a system call

    always_ff @(posedge clock) begin
        if (reset) begin
            count   <= '0;
            pending <= 1'b0;
        end else begin
            if (watchdogKick || accepted) count <= '0;
            else if (count != CountMax) count <= count + 1'b1;   // Saturates at limit
            if (accepted) pending <= 1'b0;
            else if (count == CountMax) pending <= 1'b1;
        end
    end

    assign wdInterruption = pending;

    assert property (@(posedge clock) disable iff (reset)
        $rose(pending) |-> $past(count == CountMax));

endmodule

`default_nettype wire

// File: source/InstructionDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module InstructionDecoder #(
    parameter int LinkRegister = 12
) (
    input  CorePkg::InstructionWord            instruction,
    input  logic                               isUserRequest,
    input  logic                               wdInterruption,
    output logic [CorePkg::IdWidth-1:0]        id,
    output logic [CorePkg::RegWidth-1:0]       regD,
    output logic [CorePkg::RegWidth-1:0]       regA,
    output logic [CorePkg::RegWidth-1:0]       regB,
    output logic [CorePkg::OffsetWidth-1:0]    offset,
    output logic [CorePkg::CondWidth-1:0]      branchCondition
);

    logic [CorePkg::InstrWidth-1:0] word;   // Flat view for odd slices
    logic [3:0] opcode;
    logic       op;
    logic [1:0] funct1;

    assign word   = instruction;
    assign opcode = instruction.regForm.opcode;
    assign op     = instruction.regForm.op;
    assign funct1 = word[7:6];

    always_comb begin
        id              = '0;
        regD            = '0;
        regA            = '0;
        regB            = '0;
        offset          = '0;
        branchCondition = CorePkg::CondNone;

        if (wdInterruption || isUserRequest) begin
            id     = CorePkg::IdSystemCall;   // Forced system call
            offset = isUserRequest ? 12'd3 : 12'd0;
        end else begin
            case (opcode)
                4'd0, 4'd6, 4'd7, 4'd8: begin   // Shifts, loads and stores with imm5
                    regD[2:0]   = instruction.regForm.regD;
                    regA[2:0]   = instruction.regForm.regA;
                    offset[4:0] = instruction.regForm.imm5;
                    case (opcode)
                        4'd0:    id = 7'h01 + op;
                        4'd6:    id = 7'h30 + op;
                        4'd7:    id = 7'h32 + op;
                        default: id = 7'h34 + op;
                    endcase
                end
                4'd1: begin
                    regD[2:0] = word[2:0];
                    regA[2:0] = word[5:3];
                    if (!op) begin
                        id          = 7'h03;
                        offset[4:0] = word[10:6];
                    end else begin
                        id = 7'h04 + word[10:9];
                        if (word[10]) offset[2:0] = word[8:6];   // Immediate add/sub
                        else regB[2:0] = word[8:6];
                    end
                end
                4'd2, 4'd3: begin
                    id          = ((opcode == 4'd2) ? 7'h08 : 7'h0a) + op;
                    regD[2:0]   = instruction.immForm.regD;
                    regA[2:0]   = instruction.immForm.regD;
                    offset[7:0] = instruction.immForm.imm8;
                end
                4'd4: begin
                    if (op) begin   // PC relative load
                        id          = 7'h27;
                        regD[2:0]   = instruction.immForm.regD;
                        regA        = CorePkg::RegProgramCounter;
                        regB[2:0]   = instruction.immForm.regD;
                        offset[7:0] = instruction.immForm.imm8;
                    end else begin
                        regD[2:0] = word[2:0];
                        regA[2:0] = word[2:0];
                        regB[2:0] = word[5:3];
                        case (word[10:8])
                            3'd0, 3'd1, 3'd2, 3'd3: id = 7'h0c + {word[9:8], funct1};
                            3'd4: begin   // Hi register add
                                case (funct1)
                                    2'd1:    id = 7'h1c;
                                    2'd2:    id = 7'h1d;
                                    2'd3:    id = 7'h1e;
                                    default: id = 7'h0c;
                                endcase
                                regB[3] = funct1[0];
                                regD[3] = funct1[1];
                                regA[3] = funct1[1];
                            end
                            3'd5: begin   // Hi register compare
                                case (funct1)
                                    2'd1:    id = 7'h1f;
                                    2'd2:    id = 7'h20;
                                    2'd3:    id = 7'h21;
                                    default: id = 7'h0c;
                                endcase
                                regB[3] = (funct1 == 2'd1);
                                regD[3] = funct1[1];
                                regA[3] = funct1[1];
                            end
                            3'd6: begin   // Hi register move
                                id      = 7'h22 + funct1;
                                regB[3] = funct1[0];
                                regD[3] = funct1[1];
                                regA[3] = funct1[1];
                            end
                            default: begin   // BX with condition
                                id              = 7'h26;
                                branchCondition = word[7:4];
                                regA            = CorePkg::RegProgramCounter;
                                regB            = {1'b0, word[2:0]};
                            end
                        endcase
                    end
                end
                4'd5: begin
                    id        = 7'h28 + word[11:9];
                    regD[2:0] = word[2:0];
                    regA[2:0] = word[5:3];
                    regB[2:0] = word[8:6];
                end
                4'd9, 4'd10: begin   // SP or PC relative
                    regD[2:0]   = instruction.immForm.regD;
                    offset[7:0] = instruction.immForm.imm8;
                    if (opcode == 4'd9) begin
                        id   = 7'h36 + op;
                        regA = CorePkg::RegStackPointer;
                    end else begin
                        id   = 7'h38 + op;
                        regA = op ? CorePkg::RegStackPointer : CorePkg::RegProgramCounter;
                    end
                end
                4'd11: begin
                    case (word[11:8])
                        4'd0: begin
                            if (funct1 == 2'd1) begin
                                id   = 7'h4c;
                                regA = word[3:0];
                            end else begin
                                id   = 7'h3a;
                                regD = word[3:0];
                            end
                        end
                        4'd1: begin   // BX and BLX
                            id              = word[7] ? 7'h50 : 7'h4f;
                            branchCondition = CorePkg::CondAlways;
                            regA            = word[3:0];
                            regD            = CorePkg::RegWidth'(LinkRegister);
                        end
                        4'd2, 4'd10: begin
                            id        = ((word[11:8] == 4'd2) ? 7'h3b : 7'h3f) + funct1;
                            regD[2:0] = word[2:0];
                            regB[2:0] = word[5:3];
                        end
                        4'd4, 4'd13: begin   // Push and pop, single or multiple
                            if (word[7]) begin
                                id          = (word[11:8] == 4'd4) ? 7'h4d : 7'h4e;
                                offset[6:0] = word[6:0];
                                regA        = CorePkg::RegStackPointer;
                            end else begin
                                id        = (word[11:8] == 4'd4) ? 7'h43 : 7'h44;
                                regD[2:0] = word[2:0];
                            end
                        end
                        4'd14: begin
                            case (funct1)
                                2'd0:    id = 7'h45;
                                2'd1:    id = 7'h46;   // Pause
                                2'd2:    id = 7'h47;
                                default: id = 7'h7a;
                            endcase
                            if (!funct1[0]) regD[2:0] = word[2:0];
                        end
                        default: id = 7'h7a;
                    endcase
                end
                4'd12: begin   // Software interrupt
                    id          = CorePkg::IdSystemCall;
                    offset[7:0] = instruction.immForm.imm8;
                end
                4'd13: begin
                    id              = 7'h49;
                    branchCondition = word[11:8];
                    regA            = CorePkg::RegProgramCounter;
                    offset[7:0]     = instruction.immForm.imm8;
                end
                4'd14:   id = 7'h4a + op;   // NOP or HLT
                default: id = (word == 16'hffff) ? CorePkg::IdReset : CorePkg::IdUndefined;
            endcase
        end
    end

    // Known inputs must never leave the identifier unknown
    always_comb begin
        if (!$isunknown({word, isUserRequest, wdInterruption}))
            assert final (!$isunknown(id));
    end

endmodule

`default_nettype wire

// File: source/CorePkg.sv
`default_nettype none

package CorePkg;

    localparam int InstrWidth  = 16;
    localparam int IdWidth     = 7;
    localparam int RegWidth    = 4;
    localparam int OffsetWidth = 12;
    localparam int CondWidth   = 4;

    // Identifiers checked outside the decoder
    localparam logic [IdWidth-1:0] IdSystemCall = 7'h48;
    localparam logic [IdWidth-1:0] IdReset      = 7'h64;
    localparam logic [IdWidth-1:0] IdUndefined  = 7'h7f;

    localparam logic [RegWidth-1:0] RegStackPointer   = 4'd14;
    localparam logic [RegWidth-1:0] RegProgramCounter = 4'd15;

    localparam logic [CondWidth-1:0] CondAlways = 4'he;
    localparam logic [CondWidth-1:0] CondNone   = 4'hf;

    // Same 16 bits, register layout or immediate layout
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [4:0] imm5;   // Shift amount or offset
            logic [2:0] regA;
            logic [2:0] regD;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [2:0] regD;
            logic [7:0] imm8;
        } immForm;
    } InstructionWord;

endpackage

`default_nettype wire
